/* source/regstage_pkg.sv */
package regstage_pkg;

  // Architectural register file
  localparam int gpr_count = 32;
  localparam int gpr_idx_w = 5;
  localparam int gpr_w = 64;
  localparam int zero_reg = 31;

  // Raw immediate as delivered by decode
  localparam int imm_w = 19;

  // Reorder buffer tag
  localparam int rob_idx_w = 4;

  localparam int nzcv_w = 4;

  typedef enum logic [2:0] {
    FU_OP_ADD,
    FU_OP_SUB,
    FU_OP_AND,
    FU_OP_LDUR,
    FU_OP_STUR,
    FU_OP_B_COND,
    FU_OP_ADR
  } fu_op_t;

  typedef enum logic [1:0] {
    FU_ALU,
    FU_MEM,
    FU_BRANCH
  } fu_t;

  // Standard ARM condition encodings
  typedef enum logic [3:0] {
    COND_EQ = 4'h0,
    COND_NE = 4'h1,
    COND_CS = 4'h2,
    COND_CC = 4'h3,
    COND_MI = 4'h4,
    COND_PL = 4'h5,
    COND_VS = 4'h6,
    COND_VC = 4'h7,
    COND_HI = 4'h8,
    COND_LS = 4'h9,
    COND_GE = 4'ha,
    COND_LT = 4'hb,
    COND_GT = 4'hc,
    COND_LE = 4'hd,
    COND_AL = 4'he
  } cond_t;

endpackage

/* source/dispatch_ctrl.sv */
`timescale 1ns/1ps

module dispatch_ctrl (
  input  logic                                  in_clk,
  input  logic                                  in_rst,
  input  logic                                  in_d_done,
  input  logic [regstage_pkg::gpr_idx_w-1:0]    in_d_src1,
  input  logic [regstage_pkg::gpr_idx_w-1:0]    in_d_src2,
  input  logic [regstage_pkg::gpr_idx_w-1:0]    in_d_dst,
  input  logic                                  in_d_use_imm,
  input  logic [regstage_pkg::imm_w-1:0]        in_d_imm,
  input  logic                                  in_d_signed_imm,
  input  logic                                  in_d_set_nzcv,
  input  logic                                  in_d_uses_nzcv,
  input  regstage_pkg::fu_t                     in_d_fu_id,
  input  regstage_pkg::fu_op_t                  in_d_fu_op,
  input  regstage_pkg::cond_t                   in_d_cond,
  input  logic                                  in_d_mispredict,
  input  logic [regstage_pkg::gpr_w-1:0]        in_d_pc,
  input  logic [regstage_pkg::rob_idx_w-1:0]    in_rob_next_index,
  output logic                                  out_done,
  output logic [regstage_pkg::gpr_idx_w-1:0]    stage_src1,
  output logic [regstage_pkg::gpr_idx_w-1:0]    stage_src2,
  output logic [regstage_pkg::gpr_idx_w-1:0]    stage_dst,
  output regstage_pkg::fu_op_t                  stage_op,
  output logic                                  stage_use_imm,
  output logic                                  stage_signed_imm,
  output logic [regstage_pkg::imm_w-1:0]        stage_imm,
  output logic [regstage_pkg::gpr_w-1:0]        stage_pc,
  output logic [regstage_pkg::rob_idx_w-1:0]    stage_tag,
  output logic                                  stage_set_nzcv,
  output logic                                  rename_en,
  output logic                                  nzcv_rename_en,
  output regstage_pkg::fu_t                     out_fu_id,
  output regstage_pkg::cond_t                   out_cond,
  output logic                                  out_uses_nzcv,
  output logic                                  out_mispredict
);

  // Stage valid bit, one cycle per accepted instruction
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      out_done <= 1'b0;
    end else begin
      out_done <= in_d_done;
    end
  end

  // Decode fields held for the output cycle
  always_ff @(posedge in_clk) begin
    if (in_d_done) begin
      stage_src1       <= in_d_src1;
      stage_src2       <= in_d_src2;
      stage_dst        <= in_d_dst;
      stage_op         <= in_d_fu_op;
      stage_use_imm    <= in_d_use_imm;
      stage_signed_imm <= in_d_signed_imm;
      stage_imm        <= in_d_imm;
      stage_pc         <= in_d_pc;
      stage_tag        <= in_rob_next_index;
      stage_set_nzcv   <= in_d_set_nzcv;
      out_fu_id        <= in_d_fu_id;
      out_cond         <= in_d_cond;
      out_uses_nzcv    <= in_d_uses_nzcv;
      out_mispredict   <= in_d_mispredict;
    end
  end

  // XZR never gets a new owner
  assign rename_en = out_done &&
                     (stage_dst != regstage_pkg::gpr_idx_w'(regstage_pkg::zero_reg));

  // Flags rename even when the result goes to XZR, as for CMP
  assign nzcv_rename_en = out_done && stage_set_nzcv;

  // A strobe must bring a known destination and ROB tag
  decode_fields_known: assert property (
    @(posedge in_clk) disable iff (in_rst)
    in_d_done |-> !$isunknown({in_d_dst, in_rob_next_index})
  );

endmodule

/* source/gpr_file.sv */
`timescale 1ns/1ps

module gpr_file (
  input  logic                                  in_clk,
  input  logic                                  in_rst,
  input  logic [regstage_pkg::gpr_idx_w-1:0]    rd1_idx,
  input  logic [regstage_pkg::gpr_idx_w-1:0]    rd2_idx,
  input  logic                                  rename_en,
  input  logic [regstage_pkg::gpr_idx_w-1:0]    rename_idx,
  input  logic [regstage_pkg::rob_idx_w-1:0]    rename_tag,
  input  logic                                  in_rob_commit,
  input  logic [regstage_pkg::gpr_idx_w-1:0]    in_rob_commit_reg,
  input  logic [regstage_pkg::rob_idx_w-1:0]    in_rob_commit_index,
  input  logic [regstage_pkg::gpr_w-1:0]        in_rob_commit_value,
  output logic [regstage_pkg::gpr_w-1:0]        rd1_value,
  output logic                                  rd1_valid,
  output logic [regstage_pkg::rob_idx_w-1:0]    rd1_tag,
  output logic [regstage_pkg::gpr_w-1:0]        rd2_value,
  output logic                                  rd2_valid,
  output logic [regstage_pkg::rob_idx_w-1:0]    rd2_tag
);

  localparam logic [regstage_pkg::gpr_idx_w-1:0] xzr =
    regstage_pkg::gpr_idx_w'(regstage_pkg::zero_reg);

  logic [regstage_pkg::gpr_w-1:0]     value_q [regstage_pkg::gpr_count];
  logic                               valid_q [regstage_pkg::gpr_count];
  logic [regstage_pkg::rob_idx_w-1:0] tag_q   [regstage_pkg::gpr_count];

  logic commit_hit;

  // Only the current owner may write the register back
  assign commit_hit = in_rob_commit && (in_rob_commit_reg != xzr) &&
                      (in_rob_commit_index == tag_q[in_rob_commit_reg]);

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < regstage_pkg::gpr_count; i++) begin
        value_q[i] <= '0;
        valid_q[i] <= 1'b1;
        tag_q[i]   <= '0;
      end
    end else begin
      if (commit_hit) begin
        value_q[in_rob_commit_reg] <= in_rob_commit_value;
        valid_q[in_rob_commit_reg] <= 1'b1;
      end
      // Later assignment, so a rename beats a commit to the same entry
      if (rename_en) begin
        valid_q[rename_idx] <= 1'b0;
        tag_q[rename_idx]   <= rename_tag;
      end
    end
  end

  // Read ports, XZR forced to a ready zero
  always_comb begin
    if (rd1_idx == xzr) begin
      rd1_value = '0;
      rd1_valid = 1'b1;
      rd1_tag   = '0;
    end else begin
      rd1_value = value_q[rd1_idx];
      rd1_valid = valid_q[rd1_idx];
      rd1_tag   = tag_q[rd1_idx];
    end
    if (rd2_idx == xzr) begin
      rd2_value = '0;
      rd2_valid = 1'b1;
      rd2_tag   = '0;
    end else begin
      rd2_value = value_q[rd2_idx];
      rd2_valid = valid_q[rd2_idx];
      rd2_tag   = tag_q[rd2_idx];
    end
  end

  // Relies on the control block never renaming XZR
  zero_reg_stays_valid: assert property (
    @(posedge in_clk) disable iff (in_rst)
    valid_q[regstage_pkg::zero_reg]
  );

endmodule

/* source/nzcv_flags.sv */
`timescale 1ns/1ps

module nzcv_flags (
  input  logic                                  in_clk,
  input  logic                                  in_rst,
  input  logic                                  nzcv_rename_en,
  input  logic [regstage_pkg::rob_idx_w-1:0]    rename_tag,
  input  logic                                  in_rob_commit,
  input  logic                                  in_rob_set_nzcv,
  input  logic [regstage_pkg::rob_idx_w-1:0]    in_rob_commit_index,
  input  logic [regstage_pkg::nzcv_w-1:0]       in_rob_nzcv,
  output logic [regstage_pkg::nzcv_w-1:0]       nzcv,
  output logic                                  nzcv_valid,
  output logic [regstage_pkg::rob_idx_w-1:0]    nzcv_tag
);

  logic commit_hit;

  // Commit must carry flags and come from the current owner
  assign commit_hit = in_rob_commit && in_rob_set_nzcv &&
                      (in_rob_commit_index == nzcv_tag);

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      nzcv       <= '0;
      nzcv_valid <= 1'b1;
      nzcv_tag   <= '0;
    end else begin
      if (commit_hit) begin
        nzcv       <= in_rob_nzcv;
        nzcv_valid <= 1'b1;
      end
      // Rename has the last word
      if (nzcv_rename_en) begin
        nzcv_valid <= 1'b0;
        nzcv_tag   <= rename_tag;
      end
    end
  end

endmodule

/* source/operand_select.sv */
`timescale 1ns/1ps

module operand_select (
  input  regstage_pkg::fu_op_t                  stage_op,
  input  logic                                  stage_use_imm,
  input  logic                                  stage_signed_imm,
  input  logic [regstage_pkg::imm_w-1:0]        stage_imm,
  input  logic [regstage_pkg::gpr_w-1:0]        stage_pc,
  input  logic [regstage_pkg::gpr_w-1:0]        rd1_value,
  input  logic                                  rd1_valid,
  input  logic [regstage_pkg::gpr_w-1:0]        rd2_value,
  input  logic                                  rd2_valid,
  output logic [regstage_pkg::gpr_w-1:0]        src1_value,
  output logic                                  src1_valid,
  output logic [regstage_pkg::gpr_w-1:0]        src2_value,
  output logic                                  src2_valid
);

  localparam int pad_w = regstage_pkg::gpr_w - regstage_pkg::imm_w;

  logic [regstage_pkg::gpr_w-1:0] ext_imm;
  logic                           fill;

  // Sign bit or zero fills the upper part
  assign fill    = stage_signed_imm & stage_imm[regstage_pkg::imm_w-1];
  assign ext_imm = {{pad_w{fill}}, stage_imm};

  always_comb begin
    case (stage_op)
      regstage_pkg::FU_OP_LDUR,
      regstage_pkg::FU_OP_STUR: begin
        // Address is folded here when the base is ready
        src1_valid = rd1_valid;
        if (rd1_valid) begin
          src1_value = rd1_value + ext_imm;
        end else begin
          src1_value = ext_imm;
        end
      end
      regstage_pkg::FU_OP_B_COND,
      regstage_pkg::FU_OP_ADR: begin
        src1_value = stage_pc;
        src1_valid = 1'b1;
      end
      default: begin
        src1_value = rd1_value;
        src1_valid = rd1_valid;
      end
    endcase
  end

  // Immediate form needs no register
  always_comb begin
    if (stage_use_imm) begin
      src2_value = ext_imm;
      src2_valid = 1'b1;
    end else begin
      src2_value = rd2_value;
      src2_valid = rd2_valid;
    end
  end

endmodule

/* source/reg_stage_top.sv */
`timescale 1ns/1ps

module reg_stage_top (
  input  logic                                  in_clk,
  input  logic                                  in_rst,
  input  logic                                  in_d_done,
  input  logic [regstage_pkg::gpr_idx_w-1:0]    in_d_src1,
  input  logic [regstage_pkg::gpr_idx_w-1:0]    in_d_src2,
  input  logic [regstage_pkg::gpr_idx_w-1:0]    in_d_dst,
  input  logic                                  in_d_use_imm,
  input  logic [regstage_pkg::imm_w-1:0]        in_d_imm,
  input  logic                                  in_d_signed_imm,
  input  logic                                  in_d_set_nzcv,
  input  logic                                  in_d_uses_nzcv,
  input  regstage_pkg::fu_t                     in_d_fu_id,
  input  regstage_pkg::fu_op_t                  in_d_fu_op,
  input  regstage_pkg::cond_t                   in_d_cond,
  input  logic                                  in_d_mispredict,
  input  logic [regstage_pkg::gpr_w-1:0]        in_d_pc,
  input  logic [regstage_pkg::rob_idx_w-1:0]    in_rob_next_index,
  input  logic                                  in_rob_commit,
  input  logic [regstage_pkg::gpr_idx_w-1:0]    in_rob_commit_reg,
  input  logic [regstage_pkg::rob_idx_w-1:0]    in_rob_commit_index,
  input  logic [regstage_pkg::gpr_w-1:0]        in_rob_commit_value,
  input  logic                                  in_rob_set_nzcv,
  input  logic [regstage_pkg::nzcv_w-1:0]       in_rob_nzcv,
  output logic                                  out_done,
  output logic [regstage_pkg::gpr_idx_w-1:0]    out_dst,
  output logic [regstage_pkg::gpr_w-1:0]        out_src1_value,
  output logic                                  out_src1_valid,
  output logic [regstage_pkg::rob_idx_w-1:0]    out_src1_tag,
  output logic [regstage_pkg::gpr_w-1:0]        out_src2_value,
  output logic                                  out_src2_valid,
  output logic [regstage_pkg::rob_idx_w-1:0]    out_src2_tag,
  output logic [regstage_pkg::nzcv_w-1:0]       out_nzcv,
  output logic                                  out_nzcv_valid,
  output logic [regstage_pkg::rob_idx_w-1:0]    out_nzcv_tag,
  output logic                                  out_set_nzcv,
  output logic                                  out_uses_nzcv,
  output regstage_pkg::fu_t                     out_fu_id,
  output regstage_pkg::fu_op_t                  out_fu_op,
  output regstage_pkg::cond_t                   out_cond,
  output logic                                  out_mispredict
);

  logic [regstage_pkg::gpr_idx_w-1:0] stage_src1;
  logic [regstage_pkg::gpr_idx_w-1:0] stage_src2;
  logic                               stage_use_imm;
  logic                               stage_signed_imm;
  logic [regstage_pkg::imm_w-1:0]     stage_imm;
  logic [regstage_pkg::gpr_w-1:0]     stage_pc;
  logic [regstage_pkg::rob_idx_w-1:0] stage_tag;
  logic                               rename_en;
  logic                               nzcv_rename_en;
  logic [regstage_pkg::gpr_w-1:0]     rd1_value;
  logic                               rd1_valid;
  logic [regstage_pkg::gpr_w-1:0]     rd2_value;
  logic                               rd2_valid;

  // Buffered destination, opcode and flag bit are also stage outputs
  dispatch_ctrl u_ctrl (
    .in_clk            (in_clk),
    .in_rst            (in_rst),
    .in_d_done         (in_d_done),
    .in_d_src1         (in_d_src1),
    .in_d_src2         (in_d_src2),
    .in_d_dst          (in_d_dst),
    .in_d_use_imm      (in_d_use_imm),
    .in_d_imm          (in_d_imm),
    .in_d_signed_imm   (in_d_signed_imm),
    .in_d_set_nzcv     (in_d_set_nzcv),
    .in_d_uses_nzcv    (in_d_uses_nzcv),
    .in_d_fu_id        (in_d_fu_id),
    .in_d_fu_op        (in_d_fu_op),
    .in_d_cond         (in_d_cond),
    .in_d_mispredict   (in_d_mispredict),
    .in_d_pc           (in_d_pc),
    .in_rob_next_index (in_rob_next_index),
    .out_done          (out_done),
    .stage_src1        (stage_src1),
    .stage_src2        (stage_src2),
    .stage_dst         (out_dst),
    .stage_op          (out_fu_op),
    .stage_use_imm     (stage_use_imm),
    .stage_signed_imm  (stage_signed_imm),
    .stage_imm         (stage_imm),
    .stage_pc          (stage_pc),
    .stage_tag         (stage_tag),
    .stage_set_nzcv    (out_set_nzcv),
    .rename_en         (rename_en),
    .nzcv_rename_en    (nzcv_rename_en),
    .out_fu_id         (out_fu_id),
    .out_cond          (out_cond),
    .out_uses_nzcv     (out_uses_nzcv),
    .out_mispredict    (out_mispredict)
  );

  gpr_file u_gprs (
    .in_clk              (in_clk),
    .in_rst              (in_rst),
    .rd1_idx             (stage_src1),
    .rd2_idx             (stage_src2),
    .rename_en           (rename_en),
    .rename_idx          (out_dst),
    .rename_tag          (stage_tag),
    .in_rob_commit       (in_rob_commit),
    .in_rob_commit_reg   (in_rob_commit_reg),
    .in_rob_commit_index (in_rob_commit_index),
    .in_rob_commit_value (in_rob_commit_value),
    .rd1_value           (rd1_value),
    .rd1_valid           (rd1_valid),
    .rd1_tag             (out_src1_tag),
    .rd2_value           (rd2_value),
    .rd2_valid           (rd2_valid),
    .rd2_tag             (out_src2_tag)
  );

  nzcv_flags u_flags (
    .in_clk              (in_clk),
    .in_rst              (in_rst),
    .nzcv_rename_en      (nzcv_rename_en),
    .rename_tag          (stage_tag),
    .in_rob_commit       (in_rob_commit),
    .in_rob_set_nzcv     (in_rob_set_nzcv),
    .in_rob_commit_index (in_rob_commit_index),
    .in_rob_nzcv         (in_rob_nzcv),
    .nzcv                (out_nzcv),
    .nzcv_valid          (out_nzcv_valid),
    .nzcv_tag            (out_nzcv_tag)
  );

  operand_select u_opsel (
    .stage_op         (out_fu_op),
    .stage_use_imm    (stage_use_imm),
    .stage_signed_imm (stage_signed_imm),
    .stage_imm        (stage_imm),
    .stage_pc         (stage_pc),
    .rd1_value        (rd1_value),
    .rd1_valid        (rd1_valid),
    .rd2_value        (rd2_value),
    .rd2_valid        (rd2_valid),
    .src1_value       (out_src1_value),
    .src1_valid       (out_src1_valid),
    .src2_value       (out_src2_value),
    .src2_valid       (out_src2_valid)
  );

endmodule

/* bench/tb_reg_stage.sv */
`timescale 1ns/1ps

module tb_reg_stage;

  localparam logic [1:0] row_commit   = 2'd1;
  localparam logic [1:0] row_dispatch = 2'd2;

  // One stimulus row, with the outputs expected one cycle after a dispatch
  typedef struct packed {
    logic [1:0]                         kind;
    logic [regstage_pkg::gpr_idx_w-1:0] src1;
    logic [regstage_pkg::gpr_idx_w-1:0] src2;
    logic [regstage_pkg::gpr_idx_w-1:0] dst;
    regstage_pkg::fu_op_t               op;
    logic                               use_imm;
    logic [regstage_pkg::imm_w-1:0]     imm;
    logic                               sgn;
    logic                               set_nzcv;
    logic                               uses_nzcv;
    regstage_pkg::fu_t                  fu_id;
    regstage_pkg::cond_t                cond;
    logic                               mispredict;
    logic [regstage_pkg::gpr_w-1:0]     pc;
    logic [regstage_pkg::rob_idx_w-1:0] tag;
    logic [regstage_pkg::gpr_w-1:0]     value;
    logic [regstage_pkg::nzcv_w-1:0]    nzcv;
    logic [regstage_pkg::gpr_w-1:0]     e1_val;
    logic                               e1_vld;
    logic [regstage_pkg::rob_idx_w-1:0] e1_tag;
    logic [regstage_pkg::gpr_w-1:0]     e2_val;
    logic                               e2_vld;
    logic [regstage_pkg::rob_idx_w-1:0] e2_tag;
    logic [regstage_pkg::nzcv_w-1:0]    ef;
    logic                               ef_vld;
    logic [regstage_pkg::rob_idx_w-1:0] ef_tag;
  } row_t;

  logic                               in_clk;
  logic                               in_rst;
  logic                               in_d_done;
  logic [regstage_pkg::gpr_idx_w-1:0] in_d_src1;
  logic [regstage_pkg::gpr_idx_w-1:0] in_d_src2;
  logic [regstage_pkg::gpr_idx_w-1:0] in_d_dst;
  logic                               in_d_use_imm;
  logic [regstage_pkg::imm_w-1:0]     in_d_imm;
  logic                               in_d_signed_imm;
  logic                               in_d_set_nzcv;
  logic                               in_d_uses_nzcv;
  regstage_pkg::fu_t                  in_d_fu_id;
  regstage_pkg::fu_op_t               in_d_fu_op;
  regstage_pkg::cond_t                in_d_cond;
  logic                               in_d_mispredict;
  logic [regstage_pkg::gpr_w-1:0]     in_d_pc;
  logic [regstage_pkg::rob_idx_w-1:0] in_rob_next_index;
  logic                               in_rob_commit;
  logic [regstage_pkg::gpr_idx_w-1:0] in_rob_commit_reg;
  logic [regstage_pkg::rob_idx_w-1:0] in_rob_commit_index;
  logic [regstage_pkg::gpr_w-1:0]     in_rob_commit_value;
  logic                               in_rob_set_nzcv;
  logic [regstage_pkg::nzcv_w-1:0]    in_rob_nzcv;

  logic                               out_done;
  logic [regstage_pkg::gpr_idx_w-1:0] out_dst;
  logic [regstage_pkg::gpr_w-1:0]     out_src1_value;
  logic                               out_src1_valid;
  logic [regstage_pkg::rob_idx_w-1:0] out_src1_tag;
  logic [regstage_pkg::gpr_w-1:0]     out_src2_value;
  logic                               out_src2_valid;
  logic [regstage_pkg::rob_idx_w-1:0] out_src2_tag;
  logic [regstage_pkg::nzcv_w-1:0]    out_nzcv;
  logic                               out_nzcv_valid;
  logic [regstage_pkg::rob_idx_w-1:0] out_nzcv_tag;
  logic                               out_set_nzcv;
  logic                               out_uses_nzcv;
  regstage_pkg::fu_t                  out_fu_id;
  regstage_pkg::fu_op_t               out_fu_op;
  regstage_pkg::cond_t                out_cond;
  logic                               out_mispredict;

  row_t rows[$];
  int   cycles;
  int   cycle_limit;

  // Flags that the next dispatch row is expected to see
  logic [regstage_pkg::nzcv_w-1:0]    flags_exp;
  logic                               flags_exp_vld;
  logic [regstage_pkg::rob_idx_w-1:0] flags_exp_tag;

  reg_stage_top UUT (
    .in_clk              (in_clk),
    .in_rst              (in_rst),
    .in_d_done           (in_d_done),
    .in_d_src1           (in_d_src1),
    .in_d_src2           (in_d_src2),
    .in_d_dst            (in_d_dst),
    .in_d_use_imm        (in_d_use_imm),
    .in_d_imm            (in_d_imm),
    .in_d_signed_imm     (in_d_signed_imm),
    .in_d_set_nzcv       (in_d_set_nzcv),
    .in_d_uses_nzcv      (in_d_uses_nzcv),
    .in_d_fu_id          (in_d_fu_id),
    .in_d_fu_op          (in_d_fu_op),
    .in_d_cond           (in_d_cond),
    .in_d_mispredict     (in_d_mispredict),
    .in_d_pc             (in_d_pc),
    .in_rob_next_index   (in_rob_next_index),
    .in_rob_commit       (in_rob_commit),
    .in_rob_commit_reg   (in_rob_commit_reg),
    .in_rob_commit_index (in_rob_commit_index),
    .in_rob_commit_value (in_rob_commit_value),
    .in_rob_set_nzcv     (in_rob_set_nzcv),
    .in_rob_nzcv         (in_rob_nzcv),
    .out_done            (out_done),
    .out_dst             (out_dst),
    .out_src1_value      (out_src1_value),
    .out_src1_valid      (out_src1_valid),
    .out_src1_tag        (out_src1_tag),
    .out_src2_value      (out_src2_value),
    .out_src2_valid      (out_src2_valid),
    .out_src2_tag        (out_src2_tag),
    .out_nzcv            (out_nzcv),
    .out_nzcv_valid      (out_nzcv_valid),
    .out_nzcv_tag        (out_nzcv_tag),
    .out_set_nzcv        (out_set_nzcv),
    .out_uses_nzcv       (out_uses_nzcv),
    .out_fu_id           (out_fu_id),
    .out_fu_op           (out_fu_op),
    .out_cond            (out_cond),
    .out_mispredict      (out_mispredict)
  );

  initial begin
    in_clk = 1'b0;
    forever #4 in_clk = ~in_clk;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge in_clk);
      cycles++;
      if (cycles > cycle_limit) begin
        $display("Run timed out after %0d cycles", cycles);
        $display("Simulation FAILED");
        $fatal(1, "Timeout");
      end
    end
  end

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "Stopped at first error");
    end
  endtask

  task automatic expect_flags(input logic [3:0] nzcv, input logic vld, input logic [3:0] tag);
    flags_exp     = nzcv;
    flags_exp_vld = vld;
    flags_exp_tag = tag;
  endtask

  task automatic add_dispatch(
    input logic [4:0]           src1,
    input logic [4:0]           src2,
    input logic [4:0]           dst,
    input regstage_pkg::fu_op_t op,
    input logic                 use_imm,
    input logic [18:0]          imm,
    input logic                 sgn,
    input logic                 set_nzcv,
    input logic [63:0]          pc,
    input logic [3:0]           tag
  );
    row_t r;
    r          = '0;
    r.kind     = row_dispatch;
    r.src1     = src1;
    r.src2     = src2;
    r.dst      = dst;
    r.op       = op;
    r.use_imm  = use_imm;
    r.imm      = imm;
    r.sgn      = sgn;
    r.set_nzcv = set_nzcv;
    r.pc       = pc;
    r.tag      = tag;
    // Pass-through fields vary with the row number
    if (op == regstage_pkg::FU_OP_LDUR || op == regstage_pkg::FU_OP_STUR) begin
      r.fu_id = regstage_pkg::FU_MEM;
    end else if (op == regstage_pkg::FU_OP_B_COND) begin
      r.fu_id = regstage_pkg::FU_BRANCH;
    end else begin
      r.fu_id = regstage_pkg::FU_ALU;
    end
    r.cond       = regstage_pkg::cond_t'(rows.size() % 15);
    r.mispredict = (rows.size() % 2) == 1;
    r.uses_nzcv  = (op == regstage_pkg::FU_OP_B_COND);
    r.ef         = flags_exp;
    r.ef_vld     = flags_exp_vld;
    r.ef_tag     = flags_exp_tag;
    rows.push_back(r);
  endtask

  // Expected sources of the dispatch row added last
  task automatic expect_sources(
    input logic [63:0] v1, input logic ok1, input logic [3:0] t1,
    input logic [63:0] v2, input logic ok2, input logic [3:0] t2
  );
    row_t r;
    r        = rows.pop_back();
    r.e1_val = v1;
    r.e1_vld = ok1;
    r.e1_tag = t1;
    r.e2_val = v2;
    r.e2_vld = ok2;
    r.e2_tag = t2;
    rows.push_back(r);
  endtask

  task automatic add_commit(
    input logic [4:0] creg, input logic [3:0] tag, input logic [63:0] value,
    input logic set_nzcv, input logic [3:0] nzcv
  );
    row_t r;
    r          = '0;
    r.kind     = row_commit;
    r.dst      = creg;
    r.tag      = tag;
    r.value    = value;
    r.set_nzcv = set_nzcv;
    r.nzcv     = nzcv;
    rows.push_back(r);
  endtask

  task automatic build_table();
    expect_flags(4'h0, 1'b1, 4'h0);
    // Reset state, two registers per row, XZR as destination
    for (int r = 0; r < 32; r += 2) begin
      add_dispatch(5'(r), 5'(r + 1), 5'd31, regstage_pkg::FU_OP_ADD, 0, '0, 0, 0, '0, 4'd0);
      expect_sources(64'h0, 1, 4'd0, 64'h0, 1, 4'd0);
    end
    add_dispatch(5'd2, 5'd3, 5'd1, regstage_pkg::FU_OP_ADD, 0, '0, 0, 0, '0, 4'd1);
    expect_sources(64'h0, 1, 4'd0, 64'h0, 1, 4'd0);
    // Sees the rename of x1 from the previous cycle
    add_dispatch(5'd1, 5'd1, 5'd4, regstage_pkg::FU_OP_ADD, 0, '0, 0, 0, '0, 4'd2);
    expect_sources(64'h0, 0, 4'd1, 64'h0, 0, 4'd1);
    // Source equal to destination reads the old entry
    add_dispatch(5'd5, 5'd0, 5'd5, regstage_pkg::FU_OP_ADD, 1, 19'h7fff0, 1, 0, '0, 4'd3);
    expect_sources(64'h0, 1, 4'd0, 64'hffff_ffff_ffff_fff0, 1, 4'd0);
    add_dispatch(5'd5, 5'd0, 5'd6, regstage_pkg::FU_OP_ADD, 1, 19'h7fff0, 0, 0, '0, 4'd4);
    expect_sources(64'h0, 0, 4'd3, 64'h7fff0, 1, 4'd0);
    add_commit(5'd1, 4'd1, 64'h1111, 0, 4'h0);
    // Stale tag and XZR commits are dropped
    add_commit(5'd4, 4'd5, 64'hdead, 0, 4'h0);
    add_commit(5'd31, 4'd0, 64'hbeef, 0, 4'h0);
    add_dispatch(5'd1, 5'd4, 5'd7, regstage_pkg::FU_OP_ADD, 0, '0, 0, 0, '0, 4'd5);
    expect_sources(64'h1111, 1, 4'd1, 64'h0, 0, 4'd2);
    add_dispatch(5'd31, 5'd4, 5'd31, regstage_pkg::FU_OP_AND, 0, '0, 0, 0, '0, 4'd6);
    expect_sources(64'h0, 1, 4'd0, 64'h0, 0, 4'd2);
    add_commit(5'd4, 4'd2, 64'h4000, 0, 4'h0);
    // Address formation for loads and stores
    add_dispatch(5'd4, 5'd31, 5'd9, regstage_pkg::FU_OP_LDUR, 0, 19'h10, 1, 0, '0, 4'd7);
    expect_sources(64'h4010, 1, 4'd2, 64'h0, 1, 4'd0);
    add_dispatch(5'd6, 5'd9, 5'd31, regstage_pkg::FU_OP_STUR, 0, 19'h7fff8, 1, 0, '0, 4'd8);
    expect_sources(64'hffff_ffff_ffff_fff8, 0, 4'd4, 64'h0, 0, 4'd7);
    add_dispatch(5'd31, 5'd31, 5'd31, regstage_pkg::FU_OP_B_COND, 1, 19'h20, 1, 0,
                 64'h40_1000, 4'd9);
    expect_sources(64'h40_1000, 1, 4'd0, 64'h20, 1, 4'd0);
    add_dispatch(5'd7, 5'd31, 5'd10, regstage_pkg::FU_OP_ADR, 1, 19'h100, 0, 0,
                 64'h40_2000, 4'd10);
    expect_sources(64'h40_2000, 1, 4'd5, 64'h100, 1, 4'd0);
    // Compare that only sets the flags
    add_dispatch(5'd1, 5'd4, 5'd31, regstage_pkg::FU_OP_SUB, 0, '0, 0, 1, '0, 4'd11);
    expect_sources(64'h1111, 1, 4'd1, 64'h4000, 1, 4'd2);
    expect_flags(4'h0, 1'b0, 4'd11);
    add_dispatch(5'd31, 5'd31, 5'd31, regstage_pkg::FU_OP_B_COND, 1, 19'h40, 0, 0,
                 64'h500, 4'd12);
    expect_sources(64'h500, 1, 4'd0, 64'h40, 1, 4'd0);
    add_commit(5'd31, 4'd11, 64'h77, 1, 4'h6);
    add_commit(5'd31, 4'd3, 64'h0, 1, 4'hf);
    expect_flags(4'h6, 1'b1, 4'd11);
    add_dispatch(5'd10, 5'd1, 5'd31, regstage_pkg::FU_OP_ADD, 0, '0, 0, 0, '0, 4'd13);
    expect_sources(64'h0, 0, 4'd10, 64'h1111, 1, 4'd1);
    // Rename and commit of x1 on the same edge
    add_dispatch(5'd31, 5'd31, 5'd1, regstage_pkg::FU_OP_ADD, 0, '0, 0, 0, '0, 4'd14);
    expect_sources(64'h0, 1, 4'd0, 64'h0, 1, 4'd0);
    add_commit(5'd1, 4'd1, 64'h1111, 0, 4'h0);
    // Store on the renamed x1 takes the offset alone
    add_dispatch(5'd1, 5'd31, 5'd31, regstage_pkg::FU_OP_STUR, 0, 19'h8, 1, 0, '0, 4'd15);
    expect_sources(64'h8, 0, 4'd14, 64'h0, 1, 4'd0);
  endtask

  task automatic clear_inputs();
    in_d_done           = 1'b0;
    in_d_src1           = '0;
    in_d_src2           = '0;
    in_d_dst            = '0;
    in_d_use_imm        = 1'b0;
    in_d_imm            = '0;
    in_d_signed_imm     = 1'b0;
    in_d_set_nzcv       = 1'b0;
    in_d_uses_nzcv      = 1'b0;
    in_d_fu_id          = regstage_pkg::FU_ALU;
    in_d_fu_op          = regstage_pkg::FU_OP_ADD;
    in_d_cond           = regstage_pkg::COND_EQ;
    in_d_mispredict     = 1'b0;
    in_d_pc             = '0;
    in_rob_next_index   = '0;
    in_rob_commit       = 1'b0;
    in_rob_commit_reg   = '0;
    in_rob_commit_index = '0;
    in_rob_commit_value = '0;
    in_rob_set_nzcv     = 1'b0;
    in_rob_nzcv         = '0;
  endtask

  task automatic drive_row(input row_t r);
    clear_inputs();
    if (r.kind == row_dispatch) begin
      in_d_done         = 1'b1;
      in_d_src1         = r.src1;
      in_d_src2         = r.src2;
      in_d_dst          = r.dst;
      in_d_use_imm      = r.use_imm;
      in_d_imm          = r.imm;
      in_d_signed_imm   = r.sgn;
      in_d_set_nzcv     = r.set_nzcv;
      in_d_uses_nzcv    = r.uses_nzcv;
      in_d_fu_id        = r.fu_id;
      in_d_fu_op        = r.op;
      in_d_cond         = r.cond;
      in_d_mispredict   = r.mispredict;
      in_d_pc           = r.pc;
      in_rob_next_index = r.tag;
    end else if (r.kind == row_commit) begin
      in_rob_commit       = 1'b1;
      in_rob_commit_reg   = r.dst;
      in_rob_commit_index = r.tag;
      in_rob_commit_value = r.value;
      in_rob_set_nzcv     = r.set_nzcv;
      in_rob_nzcv         = r.nzcv;
    end
  endtask

  task automatic check_dispatch(input row_t r);
    compare("out_done", out_done, 1);
    compare("out_dst", out_dst, r.dst);
    compare("out_fu_op", out_fu_op, r.op);
    compare("out_src1_value", out_src1_value, r.e1_val);
    compare("out_src1_valid", out_src1_valid, r.e1_vld);
    compare("out_src1_tag", out_src1_tag, r.e1_tag);
    compare("out_src2_value", out_src2_value, r.e2_val);
    compare("out_src2_valid", out_src2_valid, r.e2_vld);
    compare("out_src2_tag", out_src2_tag, r.e2_tag);
    compare("out_nzcv", out_nzcv, r.ef);
    compare("out_nzcv_valid", out_nzcv_valid, r.ef_vld);
    compare("out_nzcv_tag", out_nzcv_tag, r.ef_tag);
    compare("out_set_nzcv", out_set_nzcv, r.set_nzcv);
    compare("out_uses_nzcv", out_uses_nzcv, r.uses_nzcv);
    compare("out_fu_id", out_fu_id, r.fu_id);
    compare("out_cond", out_cond, r.cond);
    compare("out_mispredict", out_mispredict, r.mispredict);
  endtask

  initial begin
    row_t prev;
    logic prev_dispatch;
    in_rst = 1'b1;
    clear_inputs();
    build_table();
    cycle_limit = 4 * rows.size() + 20;
    prev_dispatch = 1'b0;
    repeat (2) @(posedge in_clk);
    @(negedge in_clk);
    in_rst = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      @(negedge in_clk);
      // Outputs of the row before are stable here
      if (prev_dispatch) begin
        check_dispatch(prev);
      end else begin
        compare("out_done", out_done, 0);
      end
      drive_row(rows[i]);
      prev = rows[i];
      prev_dispatch = (rows[i].kind == row_dispatch);
    end
    @(negedge in_clk);
    if (prev_dispatch) begin
      check_dispatch(prev);
    end
    clear_inputs();
    @(negedge in_clk);
    compare("out_done", out_done, 0);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* compile.f */
source/regstage_pkg.sv
source/dispatch_ctrl.sv
source/gpr_file.sv
source/nzcv_flags.sv
source/operand_select.sv
source/reg_stage_top.sv
bench/tb_reg_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_reg_stage
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
